//--- design/pipe_pkg.sv
package pipe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ORDER_W    = 64;             // same width as the monitor order

    // major opcodes of the kept groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000;    // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // srl and sra share funct3
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT  = 7'b0100000; // selects sub / sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                              // lui, immediate straight through
    } alu_op_t;

    // decode -> execute
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_val;         // as read at decode
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  writes_rd;
    } dec_payload_t;

    // execute -> result
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  writes_rd;
    } exe_payload_t;

endpackage

//--- design/pipe_if.sv
`timescale 1ns/1ps

// decoded instruction, one strobe per instruction
interface dec_exe_if import pipe_pkg::*; ();

    logic         valid;
    dec_payload_t payload;                      // only meaningful while valid

    modport producer (
        output valid,
        output payload
    );

    modport consumer (
        input  valid,
        input  payload
    );

endinterface

// executed instruction on its way to the result stage
interface exe_res_if import pipe_pkg::*; ();

    logic         valid;
    exe_payload_t payload;

    modport producer (
        output valid,
        output payload
    );

    modport consumer (
        input  valid,
        input  payload
    );

endinterface

// two read ports of the register file, values come back combinationally
interface reg_read_if import pipe_pkg::*; ();

    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;

    modport reader (
        output rs1_idx,
        output rs2_idx,
        input  rs1_val,
        input  rs2_val
    );

    modport file (
        input  rs1_idx,
        input  rs2_idx,
        output rs1_val,
        output rs2_val
    );

endinterface

//--- design/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    reg_read_if.reader      rf,
    dec_exe_if.producer     dec_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    dec_payload_t          dec_d;
    dec_payload_t          dec_q;
    logic                  dec_valid_q;

    // shared by OP and OP-IMM; sub only exists in the register form
    function automatic alu_op_t map_op(input logic [2:0] f3, input logic [6:0] f7,
                                       input logic is_reg);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = (is_reg && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;  // imm[10] for srai
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};   // sign extended
    assign imm_u  = {instr_i[31:12], 12'b0};

    assign rf.rs1_idx = rs1;                    // file bypasses same-edge writes
    assign rf.rs2_idx = rs2;

    always_comb begin
        dec_d           = '0;
        dec_d.inst      = instr_i;
        dec_d.rd        = rd;
        dec_d.rs1       = rs1;
        dec_d.rs2       = rs2;
        dec_d.rs1_val   = rf.rs1_val;
        dec_d.rs2_val   = rf.rs2_val;
        dec_d.imm       = imm_i;
        dec_d.alu_op    = ALU_ADD;
        dec_d.use_imm   = 1'b0;
        dec_d.writes_rd = (rd != '0);           // x0 is never written
        case (opcode)
            OPC_OP: begin
                dec_d.alu_op = map_op(funct3, funct7, 1'b1);
            end
            OPC_OP_IMM: begin
                dec_d.alu_op  = map_op(funct3, funct7, 1'b0);
                dec_d.use_imm = 1'b1;
            end
            OPC_LUI: begin
                dec_d.imm     = imm_u;
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.use_imm = 1'b1;
            end
            default: begin
                dec_d.writes_rd = 1'b0;         // unsupported, retires as no-op
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            dec_q <= dec_d;
        end
    end

    assign dec_o.valid   = dec_valid_q;
    assign dec_o.payload = dec_q;

endmodule

//--- design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    dec_exe_if.consumer           dec_i,
    exe_res_if.producer           exe_o,
    input  logic                  ret_valid_i,  // retirement of the result stage
    input  logic [REG_ADDR_W-1:0] ret_rd_i,
    input  logic [XLEN-1:0]       ret_wdata_i
);

    dec_payload_t                dec;
    logic [XLEN-1:0]             op_a;
    logic [XLEN-1:0]             rs2_fwd;
    logic [XLEN-1:0]             op_b;
    logic [4:0]                  shamt;
    logic [XLEN-1:0]             alu_res;
    logic                        exe_valid_q;
    exe_payload_t                exe_q;

    // distance one first, then distance two, then the decode-time read
    function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] idx,
                                                input logic [XLEN-1:0] dec_val);
        logic [XLEN-1:0] val;
        val = dec_val;
        if (ret_valid_i && ret_rd_i != '0 && ret_rd_i == idx) begin
            val = ret_wdata_i;
        end
        if (exe_valid_q && exe_q.writes_rd && exe_q.rd == idx) begin
            val = exe_q.result;
        end
        return val;
    endfunction

    assign dec = dec_i.payload;

    always_comb begin
        op_a    = fwd_sel(dec.rs1, dec.rs1_val);
        rs2_fwd = fwd_sel(dec.rs2, dec.rs2_val);
    end

    assign op_b  = dec.use_imm ? dec.imm : rs2_fwd;
    assign shamt = op_b[4:0];                   // only low five bits shift

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;         // lui
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid_q <= 1'b0;
        end else begin
            exe_valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            exe_q.inst      <= dec.inst;
            exe_q.rd        <= dec.rd;
            exe_q.result    <= alu_res;
            exe_q.writes_rd <= dec.writes_rd;
        end
    end

    assign exe_o.valid   = exe_valid_q;
    assign exe_o.payload = exe_q;

endmodule

//--- design/writeback_result.sv
`timescale 1ns/1ps

module writeback_result
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    exe_res_if.consumer           exe_i,
    reg_read_if.file              rf,
    output logic                  retire_valid_o,
    output logic [ORDER_W-1:0]    retire_order_o,
    output logic [XLEN-1:0]       retire_inst_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_rd_wdata_o
);

    logic [XLEN-1:0]       regs [1:NUM_REGS-1];  // x0 is hardwired
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_rd;
    logic [XLEN-1:0]       wr_data;
    logic [ORDER_W-1:0]    retired_cnt;

    assign wr_en   = exe_i.valid && exe_i.payload.writes_rd;
    assign wr_rd   = exe_i.payload.rd;
    assign wr_data = exe_i.payload.result;

    // write-first, a write on this edge is seen by the read
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en && wr_rd == idx) begin
            val = wr_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rf.rs1_val = read_reg(rf.rs1_idx);
        rf.rs2_val = read_reg(rf.rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_rd] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o <= 1'b0;
            retired_cnt    <= '0;
        end else begin
            retire_valid_o <= exe_i.valid;
            retired_cnt    <= retired_cnt + ORDER_W'(retire_valid_o);  // after each retire
        end
    end

    assign retire_order_o = retired_cnt;        // count of earlier retirements

    always_ff @(posedge clk) begin
        if (exe_i.valid) begin
            retire_inst_o     <= exe_i.payload.inst;
            retire_rd_o       <= wr_en ? wr_rd : '0;     // no-ops report zero
            retire_rd_wdata_o <= wr_en ? wr_data : '0;
        end
    end

endmodule

//--- design/rv32_core.sv
`timescale 1ns/1ps

module rv32_core
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_i,
    output logic                  retire_valid_o,
    output logic [ORDER_W-1:0]    retire_order_o,
    output logic [XLEN-1:0]       retire_inst_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_rd_wdata_o
);

    dec_exe_if  dec_exe ();
    exe_res_if  exe_res ();
    reg_read_if reg_rd ();

    inst_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf            (reg_rd),                // operand reads
        .dec_o         (dec_exe)
    );

    alu_execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .dec_i         (dec_exe),
        .exe_o         (exe_res),
        .ret_valid_i   (retire_valid_o),        // distance two forwarding
        .ret_rd_i      (retire_rd_o),
        .ret_wdata_i   (retire_rd_wdata_o)
    );

    writeback_result u_result (
        .clk               (clk),
        .rst               (rst),
        .exe_i             (exe_res),
        .rf                (reg_rd),
        .retire_valid_o    (retire_valid_o),
        .retire_order_o    (retire_order_o),
        .retire_inst_o     (retire_inst_o),
        .retire_rd_o       (retire_rd_o),
        .retire_rd_wdata_o (retire_rd_wdata_o)
    );

endmodule

//--- bench/core_ref.svh
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// architectural register state
logic [XLEN-1:0] ref_regs [0:NUM_REGS-1];

function automatic void ref_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        ref_regs[i] = '0;
    end
endfunction

// expected retirement of one instruction and its register update
function automatic void ref_exec(input  logic [XLEN-1:0]       inst,
                                 output logic [REG_ADDR_W-1:0] rd,
                                 output logic [XLEN-1:0]       val);
    logic [6:0]      opc;
    logic            alt;
    logic            wr;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    opc = inst[6:0];
    alt = inst[30];                             // funct7 bit 5 or srai imm bit 10
    a   = ref_regs[inst[19:15]];
    b   = (opc == OPC_OP) ? ref_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    res = '0;
    wr  = (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) && inst[11:7] != 5'd0;
    if (opc == OPC_LUI) begin
        res = {inst[31:12], 12'h000};
    end else begin
        case (inst[14:12])
            F3_ADD:  res = (opc == OPC_OP && alt) ? a - b : a + b;
            F3_SLL:  res = a << b[4:0];
            F3_SLT: begin
                if (a[31] != b[31]) begin
                    res = {31'b0, a[31]};       // negative side is the smaller
                end else begin
                    res = (a < b) ? 32'd1 : 32'd0;
                end
            end
            F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  res = a ^ b;
            F3_SR: begin
                res = a >> b[4:0];
                if (alt) begin
                    res = res | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> b[4:0]));  // sign fill
                end
            end
            F3_OR:   res = a | b;
            default: res = a & b;               // and
        endcase
    end
    rd  = wr ? inst[11:7] : 5'd0;               // no-ops report zero
    val = wr ? res : '0;
    if (wr) begin
        ref_regs[rd] = res;
    end
endfunction

`endif

//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb import pipe_pkg::*; ();

    localparam int SEED       = 48684;
    localparam int CLK_NS     = 40;
    localparam int RESET_CYC  = 16;
    localparam int N_RAND     = 48;             // per random group
    localparam int N_CHAIN    = 16;
    localparam int N_GAP      = 64;
    localparam int MAX_GAP    = 3;
    localparam int N_INST     = 14 + 2 * N_RAND + 4 + N_CHAIN + 7 + N_GAP;
    localparam int IDLE_CYC   = 6 + 2 + N_GAP * MAX_GAP + 8 + 1;
    localparam int MARGIN_CYC = 50;
    localparam int TIMEOUT_NS = (N_INST + IDLE_CYC + RESET_CYC + MARGIN_CYC) * CLK_NS;

    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       val;
    } retire_t;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic                  retire_valid_o;
    logic [ORDER_W-1:0]    retire_order_o;
    logic [XLEN-1:0]       retire_inst_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_rd_wdata_o;

    retire_t            exp_q [$];              // oldest first
    int                 due_q [$];              // edge at which each retirement is due
    logic [ORDER_W-1:0] exp_order;
    int                 edge_cnt   = 0;
    int                 value_errs = 0;
    int                 other_errs = 0;

    `include "core_ref.svh"

    rv32_core u_dut (
        .clk               (clk),
        .rst               (rst),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .retire_valid_o    (retire_valid_o),
        .retire_order_o    (retire_order_o),
        .retire_inst_o     (retire_inst_o),
        .retire_rd_o       (retire_rd_o),
        .retire_rd_wdata_o (retire_rd_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [XLEN-1:0] op_word(input logic [2:0] f3, input logic alt,
                                                input logic [4:0] rd, rs1, rs2);
        logic use_alt;
        use_alt = alt && (f3 == F3_ADD || f3 == F3_SR);  // only sub and sra
        return {(use_alt ? F7_ALT : 7'b0), rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] imm_word(input logic [2:0] f3, input logic [11:0] imm,
                                                 input logic [4:0] rd, rs1);
        logic [11:0] enc;
        enc = imm;
        if (f3 == F3_SLL || f3 == F3_SR) begin
            enc[11:5] = (f3 == F3_SR && imm[10]) ? F7_ALT : 7'b0;  // legal shift form
        end
        return {enc, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // small register set so that dependencies come up often
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(7, 0));
    endfunction

    function automatic logic [XLEN-1:0] rand_inst();
        logic [XLEN-1:0] w;
        int              kind;
        kind = $urandom_range(9, 0);
        if (kind < 4) begin
            w = op_word(3'($urandom), 1'($urandom), pick_reg(), pick_reg(), pick_reg());
        end else if (kind < 8) begin
            w = imm_word(3'($urandom), 12'($urandom), pick_reg(), pick_reg());
        end else if (kind == 8) begin
            w = lui_word(20'($urandom), pick_reg());
        end else begin
            w = {25'($urandom), 7'b1110011};    // system opcode, unsupported
        end
        return w;
    endfunction

    task automatic send(input logic [XLEN-1:0] inst);
        retire_t               e;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       val;
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= inst;
        ref_exec(inst, rd, val);
        e.inst = inst;
        e.rd   = rd;
        e.val  = val;
        exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("error %0t: %s expected %h got %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_retire();
        retire_t e;
        int      due;
        if (exp_q.size() == 0 || due_q.size() == 0) begin
            $display("unexpected retirement at %0t with no instruction outstanding", $time);
            other_errs++;
        end else begin
            e   = exp_q.pop_front();
            due = due_q.pop_front();
            if (edge_cnt != due) begin
                $display("retirement came at edge %0d, it was due at edge %0d", edge_cnt, due);
                other_errs++;
            end
            check_val("retire_inst_o", 64'(e.inst), 64'(retire_inst_o));
            check_val("retire_rd_o", 64'(e.rd), 64'(retire_rd_o));
            check_val("retire_rd_wdata_o", 64'(e.val), 64'(retire_rd_wdata_o));
            check_val("retire_order_o", exp_order, retire_order_o);
            exp_order++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            if (edge_cnt > 0 && retire_valid_o !== 1'b0) begin
                $display("retire_valid_o is not low during reset at %0t", $time);
                other_errs++;
            end
        end else begin
            if (retire_valid_o === 1'b1) begin
                check_retire();
            end else if (retire_valid_o !== 1'b0) begin
                $display("retire_valid_o is unknown at %0t", $time);
                other_errs++;
            end
            if (instr_valid_i) begin
                due_q.push_back(edge_cnt + 3);  // sampled next edge, three edges to retire
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        exp_order     = '0;
        ref_reset();
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        idle(6);                                // nothing may retire here
        for (int r = 1; r < 8; r++) begin
            send(lui_word(20'($urandom), 5'(r)));
            send(imm_word(F3_ADD, 12'($urandom), 5'(r), 5'(r)));
        end
        for (int i = 0; i < N_RAND; i++) begin  // every funct3, sub and sra on odd rounds
            send(op_word(3'(i % 8), (i / 8) % 2 == 1, pick_reg(), pick_reg(), pick_reg()));
        end
        idle(2);
        for (int i = 0; i < N_RAND; i++) begin
            if (i % 9 == 8) begin
                send(lui_word(20'($urandom), pick_reg()));
            end else begin
                send(imm_word(3'(i % 9), 12'($urandom), pick_reg(), pick_reg()));
            end
        end
        for (int r = 8; r < 12; r++) begin
            send(lui_word(20'($urandom), 5'(r)));
        end
        // rs1 at distance one, rs2 alternating distance two and three
        for (int i = 0; i < N_CHAIN; i++) begin
            send(op_word(F3_ADD, i % 2 == 1, 5'(8 + i % 4), 5'(8 + (i + 3) % 4),
                         5'(8 + (i + 2 - i % 2) % 4)));
        end
        send(imm_word(F3_ADD, 12'h123, 5'd0, 5'd1));
        send(op_word(F3_ADD, 1'b0, 5'd2, 5'd0, 5'd0));
        send({20'($urandom), 5'd3, 7'b0000011}); // load
        send({20'($urandom), 5'd4, 7'b1100011}); // branch
        send({20'($urandom), 5'd5, 7'b0010111}); // auipc
        send(op_word(F3_OR, 1'b0, 5'd6, 5'd3, 5'd4));
        send(imm_word(F3_ADD, 12'h000, 5'd7, 5'd5));
        for (int i = 0; i < N_GAP; i++) begin
            send(rand_inst());
            idle($urandom_range(MAX_GAP, 0));
        end
        idle(8);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d instructions were sent but never retired", exp_q.size());
            other_errs++;
        end
        $display("retired %0d, value errors %0d, other errors %0d",
                 exp_order, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
design/pipe_pkg.sv
design/pipe_if.sv
design/inst_decode.sv
design/alu_execute.sv
design/writeback_result.sv
design/rv32_core.sv
bench/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard bench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
